// File: include/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

////////////////////////////////////////////////////////////
// cache geometry
////////////////////////////////////////////////////////////

// 16 sets
`define DCACHE_INDEX_WIDTH  4

// 4 words per line
`define DCACHE_OFFSET_WIDTH 2

// single LRU bit per set, so two ways only
`define DCACHE_WAYS         2

// address = tag | index | word offset | byte offset
`define DCACHE_TAG_WIDTH    (32 - `DCACHE_INDEX_WIDTH - `DCACHE_OFFSET_WIDTH - 2)
`define DCACHE_LINE_BITS    (32 * (1 << `DCACHE_OFFSET_WIDTH))

`endif

// File: hdl/dcache_pkg.sv
package dcache_pkg;

    ////////////////////////////////////////////////////////////
    // controller states and cache ops
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_REQ,
        MISS_WAIT,
        REFILL,
        WT_REQ,
        CACHEOP
    } dcache_state_t;

    typedef enum logic {
        OP_INV_INDEX,
        OP_INV_HIT
    } cache_op_t;

    ////////////////////////////////////////////////////////////
    // request, lookup result, memory request
    ////////////////////////////////////////////////////////////

    // pipeline request as captured on acceptance
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic        wr;
        logic        cacheop;
        cache_op_t   op;
    } dcache_req_t;

    typedef struct packed {
        logic hit;
        logic hit_way;
        logic lru_way;
    } lookup_t;

    // single-beat bus request for a line refill or a word store
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic        wr;
    } mem_req_t;

endpackage

// File: hdl/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic          clk,
    input  logic          rstn,
    input  logic          valid,
    output logic          ready,
    input  dcache_req_t   req,
    output logic          done,
    input  lookup_t       lookup,
    input  logic          mem_addr_ok,
    input  logic          mem_data_ok,
    output logic          mem_req,
    output dcache_req_t   req_q,
    output logic          tag_we,
    output logic          tag_inv,
    output logic          data_wr_word,
    output logic          data_wr_line,
    output logic          way_sel,
    output logic          port_load,
    output dcache_state_t state
);

    // lowest bit of the tag field picks the way for invalidate by index
    localparam int TAG_LSB = `DCACHE_OFFSET_WIDTH + `DCACHE_INDEX_WIDTH + 2;

    dcache_state_t state_nxt;
    logic          accept;
    logic          is_access;
    logic          rd_hit;

    assign accept    = valid & ready;
    assign is_access = (state == LOOKUP) && !req_q.cacheop;
    assign rd_hit    = is_access && !req_q.wr && lookup.hit;

    ////////////////////////////////////////////////////////////
    // handshakes
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            LOOKUP:  done = rd_hit;
            REFILL:  done = 1'b1;
            WT_REQ:  done = mem_addr_ok;
            CACHEOP: done = 1'b1;
            default: done = 1'b0;
        endcase
    end

    // a completion cycle can take the next request
    assign ready   = (state == IDLE) || done;
    assign mem_req = (state == MISS_REQ) || (state == WT_REQ);

    ////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (valid) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                if (req_q.cacheop) begin
                    state_nxt = CACHEOP;
                end else if (req_q.wr) begin
                    state_nxt = WT_REQ;
                end else if (!lookup.hit) begin
                    state_nxt = MISS_REQ;
                end
            end
            MISS_REQ: begin
                if (mem_addr_ok) begin
                    state_nxt = MISS_WAIT;
                end
            end
            MISS_WAIT: begin
                if (mem_data_ok) begin
                    state_nxt = REFILL;
                end
            end
            default: state_nxt = state;
        endcase
        // back to back or back to idle after any completion
        if (done) begin
            state_nxt = valid ? LOOKUP : IDLE;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    ////////////////////////////////////////////////////////////
    // array and port strobes
    ////////////////////////////////////////////////////////////

    assign tag_we       = (state == REFILL);
    assign data_wr_line = (state == REFILL);
    assign data_wr_word = is_access && req_q.wr && lookup.hit;
    assign tag_inv      = (state == CACHEOP) && ((req_q.op == OP_INV_INDEX) || lookup.hit);
    // refill request on a read miss, write-through on every store
    assign port_load    = is_access && (req_q.wr || !lookup.hit);

    always_comb begin
        if (state == REFILL) begin
            way_sel = lookup.lru_way;
        end else if ((state == CACHEOP) && (req_q.op == OP_INV_INDEX)) begin
            way_sel = req_q.addr[TAG_LSB];
        end else begin
            way_sel = lookup.hit_way;
        end
    end

endmodule

// File: hdl/dcache_tag_array.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tag_array
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  dcache_req_t req_q,
    input  logic        tag_we,
    input  logic        tag_inv,
    input  logic        way_sel,
    input  logic        touch,
    output lookup_t     lookup
);

    localparam int SETS    = 1 << `DCACHE_INDEX_WIDTH;
    localparam int IDX_LSB = `DCACHE_OFFSET_WIDTH + 2;
    localparam int TAG_LSB = IDX_LSB + `DCACHE_INDEX_WIDTH;

    logic [`DCACHE_TAG_WIDTH-1:0]   tags [`DCACHE_WAYS][SETS];
    logic [SETS-1:0]                valid [`DCACHE_WAYS];
    logic [SETS-1:0]                lru;
    logic [`DCACHE_INDEX_WIDTH-1:0] idx;
    logic [`DCACHE_TAG_WIDTH-1:0]   tag;
    logic [`DCACHE_WAYS-1:0]        way_hit;

    assign idx = req_q.addr[TAG_LSB-1:IDX_LSB];
    assign tag = req_q.addr[31:TAG_LSB];

    ////////////////////////////////////////////////////////////
    // compare
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            way_hit[w] = valid[w][idx] && (tags[w][idx] == tag);
        end
    end

    assign lookup.hit     = |way_hit;
    assign lookup.hit_way = way_hit[1];
    assign lookup.lru_way = lru[idx];

    ////////////////////////////////////////////////////////////
    // valid and LRU state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '{default: '0};
            lru   <= '0;
        end else begin
            if (tag_we) begin
                valid[way_sel][idx] <= 1'b1;
            end else if (tag_inv) begin
                valid[way_sel][idx] <= 1'b0;
            end
            // point away from the way just used unless it was a cache op
            if (touch && !req_q.cacheop) begin
                if (tag_we) begin
                    lru[idx] <= ~way_sel;
                end else if (lookup.hit) begin
                    lru[idx] <= ~lookup.hit_way;
                end
            end
        end
    end

    // tag storage
    always_ff @(posedge clk) begin
        if (tag_we) begin
            tags[way_sel][idx] <= tag;
        end
    end

endmodule

// File: hdl/dcache_data_array.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_data_array
    import dcache_pkg::*;
(
    input  logic                         clk,
    input  dcache_req_t                  req_q,
    input  logic                         way_sel,
    input  logic                         hit_way,
    input  logic                         data_wr_word,
    input  logic                         data_wr_line,
    input  logic [`DCACHE_LINE_BITS-1:0] refill_line,
    output logic [31:0]                  rdata
);

    localparam int SETS    = 1 << `DCACHE_INDEX_WIDTH;
    localparam int WORDS   = 1 << `DCACHE_OFFSET_WIDTH;
    localparam int IDX_LSB = `DCACHE_OFFSET_WIDTH + 2;

    logic [31:0]                     words [`DCACHE_WAYS][SETS][WORDS];
    logic [`DCACHE_INDEX_WIDTH-1:0]  idx;
    logic [`DCACHE_OFFSET_WIDTH-1:0] off;

    assign idx = req_q.addr[IDX_LSB +: `DCACHE_INDEX_WIDTH];
    assign off = req_q.addr[2 +: `DCACHE_OFFSET_WIDTH];

    ////////////////////////////////////////////////////////////
    // writes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (data_wr_line) begin
            // word 0 sits in the low bits of the line
            for (int w = 0; w < WORDS; w++) begin
                words[way_sel][idx][w] <= refill_line[w*32 +: 32];
            end
        end else if (data_wr_word) begin
            // store merge of the strobed bytes only
            for (int b = 0; b < 4; b++) begin
                if (req_q.strb[b]) begin
                    words[way_sel][idx][off][b*8 +: 8] <= req_q.wdata[b*8 +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read
    ////////////////////////////////////////////////////////////

    // bypass from the refill line while it is being written
    assign rdata = data_wr_line ? refill_line[off*32 +: 32] : words[hit_way][idx][off];

endmodule

// File: hdl/dcache_mem_port.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_mem_port
    import dcache_pkg::*;
(
    input  logic                         clk,
    input  logic                         rstn,
    input  dcache_req_t                  req_q,
    input  logic                         port_load,
    input  dcache_state_t                state,
    input  logic                         mem_data_ok,
    input  logic [`DCACHE_LINE_BITS-1:0] mem_line,
    output mem_req_t                     mem,
    output logic [`DCACHE_LINE_BITS-1:0] refill_line
);

    localparam int LINE_LSB = `DCACHE_OFFSET_WIDTH + 2;

    ////////////////////////////////////////////////////////////
    // request fields
    ////////////////////////////////////////////////////////////

    // held until the next load so mem stays stable through addr_ok
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mem <= '0;
        end else if (port_load) begin
            if (req_q.wr) begin
                // write-through of one word
                mem.addr  <= {req_q.addr[31:2], 2'b00};
                mem.wdata <= req_q.wdata;
                mem.strb  <= req_q.strb;
                mem.wr    <= 1'b1;
            end else begin
                // line refill
                mem.addr  <= {req_q.addr[31:LINE_LSB], {LINE_LSB{1'b0}}};
                mem.wdata <= '0;
                mem.strb  <= '0;
                mem.wr    <= 1'b0;
            end
        end
    end

    // refill beat
    always_ff @(posedge clk) begin
        if ((state == MISS_WAIT) && mem_data_ok) begin
            refill_line <= mem_line;
        end
    end

endmodule

// File: hdl/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic                         clk,
    input  logic                         rstn,
    // pipeline side
    input  logic                         valid,
    output logic                         ready,
    input  dcache_req_t                  req,
    output logic                         done,
    output logic [31:0]                  rdata,
    // memory side
    output logic                         mem_req,
    output mem_req_t                     mem,
    input  logic                         mem_addr_ok,
    input  logic                         mem_data_ok,
    input  logic [`DCACHE_LINE_BITS-1:0] mem_line
);

    dcache_req_t                  req_q;
    lookup_t                      lookup;
    dcache_state_t                state;
    logic                         tag_we;
    logic                         tag_inv;
    logic                         data_wr_word;
    logic                         data_wr_line;
    logic                         way_sel;
    logic                         port_load;
    logic [`DCACHE_LINE_BITS-1:0] refill_line;

    dcache_ctrl ctrl0 (
        .clk          (clk),
        .rstn         (rstn),
        .valid        (valid),
        .ready        (ready),
        .req          (req),
        .done         (done),
        .lookup       (lookup),
        .mem_addr_ok  (mem_addr_ok),
        .mem_data_ok  (mem_data_ok),
        .mem_req      (mem_req),
        .req_q        (req_q),
        .tag_we       (tag_we),
        .tag_inv      (tag_inv),
        .data_wr_word (data_wr_word),
        .data_wr_line (data_wr_line),
        .way_sel      (way_sel),
        .port_load    (port_load),
        .state        (state)
    );

    // LRU moves on completion of a hit or a refill
    dcache_tag_array tag0 (
        .clk     (clk),
        .rstn    (rstn),
        .req_q   (req_q),
        .tag_we  (tag_we),
        .tag_inv (tag_inv),
        .way_sel (way_sel),
        .touch   (done),
        .lookup  (lookup)
    );

    dcache_data_array data0 (
        .clk          (clk),
        .req_q        (req_q),
        .way_sel      (way_sel),
        .hit_way      (lookup.hit_way),
        .data_wr_word (data_wr_word),
        .data_wr_line (data_wr_line),
        .refill_line  (refill_line),
        .rdata        (rdata)
    );

    dcache_mem_port port0 (
        .clk         (clk),
        .rstn        (rstn),
        .req_q       (req_q),
        .port_load   (port_load),
        .state       (state),
        .mem_data_ok (mem_data_ok),
        .mem_line    (mem_line),
        .mem         (mem),
        .refill_line (refill_line)
    );

endmodule

// File: test/dcache_properties.sv
`timescale 1ns/1ps

module dcache_properties
    import dcache_pkg::*;
(
    input logic     clk,
    input logic     rstn,
    input logic     valid,
    input logic     ready,
    input logic     done,
    input logic     mem_req,
    input logic     mem_addr_ok,
    input mem_req_t mem
);

    int   fail_count = 0;
    logic busy;

    // open request between acceptance and done
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy <= 1'b0;
        end else if (valid && ready) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // handshake rules
    ////////////////////////////////////////////////////////////

    a_mem_stable: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_addr_ok |=> $stable(mem))
    else begin
        fail_count++;
        $error("memory request changed before addr_ok");
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
        done |=> !done)
    else begin
        fail_count++;
        $error("done held longer than one cycle");
    end

    a_ready_low: assert property (@(posedge clk) disable iff (!rstn)
        busy && !done |-> !ready)
    else begin
        fail_count++;
        $error("ready high while a request is in progress");
    end

endmodule

bind dcache_top dcache_properties props0 (
    .clk         (clk),
    .rstn        (rstn),
    .valid       (valid),
    .ready       (ready),
    .done        (done),
    .mem_req     (mem_req),
    .mem_addr_ok (mem_addr_ok),
    .mem         (mem)
);

// File: test/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tb
    import dcache_pkg::*;
();

    localparam int RESET_CYCLES = 5;
    localparam int CYCLES_PER_LINE = 64;
    localparam int FIELDS = 7;
    localparam int MAX_LINES = 64;
    localparam int MEM_WORDS = 16384;

    logic                         clk;
    logic                         rstn;
    logic                         valid;
    logic                         ready;
    dcache_req_t                  req;
    logic                         done;
    logic [31:0]                  rdata;
    logic                         mem_req;
    mem_req_t                     mem;
    logic                         mem_addr_ok;
    logic                         mem_data_ok;
    logic [`DCACHE_LINE_BITS-1:0] mem_line;

    logic [31:0] mem_words [MEM_WORDS];
    logic [31:0] gold [FIELDS*MAX_LINES];
    int          rd_count;
    int          wr_count;
    mem_req_t    last_rd;
    mem_req_t    last_wr;
    int          cur_access;
    int          data_errors = 0;
    int          count_errors = 0;
    int          req_errors = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    dcache_top dut0 (
        .clk         (clk),
        .rstn        (rstn),
        .valid       (valid),
        .ready       (ready),
        .req         (req),
        .done        (done),
        .rdata       (rdata),
        .mem_req     (mem_req),
        .mem         (mem),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_line    (mem_line)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: no completion after %0d cycles", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // memory model
    ////////////////////////////////////////////////////////////

    initial begin : mem_model
        int unsigned delay;
        mem_req_t    cur;
        logic [13:0] widx;
        void'($urandom(32'h2b50_3a13));
        @(posedge rstn);
        forever begin
            @(negedge clk);
            if (mem_req) begin
                cur = mem;
                delay = $urandom_range(3, 0);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #1;
                mem_addr_ok = 1'b1;
                if (cur.wr) begin
                    widx = cur.addr[15:2];
                    for (int b = 0; b < 4; b++) begin
                        if (cur.strb[b]) begin
                            mem_words[widx][b*8 +: 8] = cur.wdata[b*8 +: 8];
                        end
                    end
                    wr_count++;
                    last_wr = cur;
                end else begin
                    rd_count++;
                    last_rd = cur;
                end
                @(posedge clk);
                #1;
                mem_addr_ok = 1'b0;
                if (!cur.wr) begin
                    delay = $urandom_range(3, 0);
                    repeat (delay) begin
                        @(posedge clk);
                        #1;
                    end
                    for (int w = 0; w < 4; w++) begin
                        widx = {cur.addr[15:4], 2'(w)};
                        mem_line[w*32 +: 32] = mem_words[widx];
                    end
                    mem_data_ok = 1'b1;
                    @(posedge clk);
                    #1;
                    mem_data_ok = 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            data_errors++;
            $display("[ERROR] access %0d: %s got %08h expected %08h",
                     cur_access, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            count_errors++;
            $display("[ERROR] access %0d: %s got %0h expected %0h",
                     cur_access, name, got, exp);
        end
    endtask

    task automatic check_mem_req(input string name, input mem_req_t got,
                                 input mem_req_t exp);
        if (got !== exp) begin
            req_errors++;
            $display("[ERROR] access %0d: %s got %h expected %h",
                     cur_access, name, got, exp);
        end
    endtask

    // drive one golden line and check it once done
    task automatic run_access(input int n);
        logic [31:0] kind;
        logic [31:0] exp_rdata;
        dcache_req_t r;
        mem_req_t    exp_mem;
        kind = gold[n*FIELDS];
        exp_rdata = gold[n*FIELDS+4];
        r = '0;
        r.addr = gold[n*FIELDS+1];
        r.wdata = gold[n*FIELDS+2];
        r.strb = gold[n*FIELDS+3][3:0];
        r.wr = (kind == 32'd1);
        r.cacheop = (kind >= 32'd2);
        r.op = (kind == 32'd3) ? OP_INV_HIT : OP_INV_INDEX;
        cur_access = n;
        rd_count = 0;
        wr_count = 0;
        valid = 1'b1;
        req = r;
        do @(negedge clk); while (!ready);
        @(posedge clk);
        #1;
        valid = 1'b0;
        do @(negedge clk); while (!done);
        if (kind == 32'd0) begin
            check_word("rdata", rdata, exp_rdata);
        end
        @(posedge clk);
        #1;
        check_count("memory reads", rd_count, int'(gold[n*FIELDS+5]));
        check_count("memory writes", wr_count, int'(gold[n*FIELDS+6]));
        if (rd_count > 0) begin
            exp_mem = '0;
            exp_mem.addr = {r.addr[31:4], 4'h0};
            check_mem_req("refill request", last_rd, exp_mem);
        end
        if (wr_count > 0) begin
            exp_mem.addr = {r.addr[31:2], 2'b00};
            exp_mem.wdata = r.wdata;
            exp_mem.strb = r.strb;
            exp_mem.wr = 1'b1;
            check_mem_req("store request", last_wr, exp_mem);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int num_lines;
        int assert_errors;
        rstn = 1'b0;
        valid = 1'b0;
        req = '0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_line = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[i] = 32'(i) ^ 32'hA5A5_0000;
        end
        for (int i = 0; i < FIELDS*MAX_LINES; i++) begin
            gold[i] = 32'hFFFF_FFFF;
        end
        $readmemh("test/dcache_golden.dat", gold);
        num_lines = 0;
        while (num_lines < MAX_LINES && gold[num_lines*FIELDS] != 32'hFFFF_FFFF) begin
            num_lines++;
        end
        cycle_limit = num_lines * CYCLES_PER_LINE + RESET_CYCLES;
        if (num_lines == 0) begin
            $display("no accesses found in the golden file");
            data_errors++;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
        for (int n = 0; n < num_lines; n++) begin
            run_access(n);
        end
        assert_errors = dut0.props0.fail_count;
        $display("errors: rdata %0d, traffic %0d, request %0d, assertions %0d",
                 data_errors, count_errors, req_errors, assert_errors);
        if (data_errors + count_errors + req_errors + assert_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+include
hdl/dcache_pkg.sv
hdl/dcache_ctrl.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_array.sv
hdl/dcache_mem_port.sv
hdl/dcache_top.sv
test/dcache_properties.sv
test/dcache_tb.sv

// File: Makefile
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
BUILD_DIR ?= obj_dir
FILE_LIST ?= src.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation PASSED

SRCS := $(shell grep -v '^+' $(FILE_LIST))
INCS := $(wildcard include/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(FILE_LIST) $(SRCS) $(INCS)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: test/dcache_golden.dat
// kind (0 read, 1 write, 2 inv index, 3 inv hit), addr, wdata, strb
// expected rdata, expected memory reads, expected memory writes
0 00000040 00000000 0 a5a50010 1 0
0 00000048 00000000 0 a5a50012 0 0
1 00000044 11223344 3 00000000 0 1
0 00000044 00000000 0 a5a53344 0 0
1 00000080 deadbeef c 00000000 0 1
0 00000080 00000000 0 dead0020 1 0
// set 0 lines A 0x100, B 0x200, C 0x300
0 00000104 00000000 0 a5a50041 1 0
0 00000208 00000000 0 a5a50082 1 0
0 00000100 00000000 0 a5a50040 0 0
0 0000030c 00000000 0 a5a500c3 1 0
0 00000108 00000000 0 a5a50042 0 0
0 00000200 00000000 0 a5a50080 1 0
3 00000100 00000000 0 00000000 0 0
0 00000104 00000000 0 a5a50041 1 0
2 00000000 00000000 0 00000000 0 0
0 00000204 00000000 0 a5a50081 0 0
0 00000100 00000000 0 a5a50040 1 0
0 0000020c 00000000 0 a5a50083 0 0
0 00000040 00000000 0 a5a50010 0 0
